/* Bender.yml */
package:
  name: zports

sources:
  - zport_pkg.sv
  - io_cycle_detect.sv
  - port_decoder.sv
  - paging_regs.sv
  - border_sd_regs.sv
  - read_mux.sv
  - zports_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_zports.sv

/* border_sd_regs.sv */
/* border takes ~a3 as its top bit, so FE and F6 write different values
   sd_start fires once per sd data access, one cycle after the strobe */
`timescale 1ns/1ps
`default_nettype none

module border_sd_regs import zport_pkg::*; (
	input  wire        zclk,
	input  wire        rst_n,
	input  z80_bus_t   bus,
	input  io_strobe_t strobe,
	input  reg_wr_t    reg_wr,
	output logic [3:0] border,
	output logic       beeper_wr,
	output logic       sdcs_n,
	output logic       sd_start,
	output byte_t      sd_datain
);

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			border   <= 4'h0;
			sdcs_n   <= 1'b1;       // card deselected
			sd_start <= 1'b0;
		end
		else
		begin
			if (reg_wr.border_wr)
				border <= {~bus.addr[3], bus.wdata[2:0]};
			if (reg_wr.sdcfg_wr)
				sdcs_n <= bus.wdata[1];
			sd_start <= reg_wr.sd_access; // kick the spi engine
		end
	end

	// beeper only on exact FE
	assign beeper_wr = strobe.port_wr && (bus.addr[7:0] == PORT_FE);

	// spi shifts FF out on reads
	assign sd_datain = bus.wr_n ? IDLE_BYTE : bus.wdata;

endmodule

`default_nettype wire

/* io_cycle_detect.sv */
/* a port cycle must hold iorq_n and rd_n/wr_n low for two zclk edges
   and must end before the next strobe can fire */
`timescale 1ns/1ps
`default_nettype none

module io_cycle_detect import zport_pkg::*; (
	input  wire        zclk,
	input  wire        rst_n,
	input  z80_bus_t   bus,
	output io_strobe_t strobe
);

	logic iord_act, iowr_act;   // cycle active right now
	logic iord_prev, iowr_prev; // as seen on the last edge

	assign iord_act = ~(bus.iorq_n | bus.rd_n);
	assign iowr_act = ~(bus.iorq_n | bus.wr_n);

	// rising edge of the active state gives the pulse
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			iord_prev      <= 1'b0;
			iowr_prev      <= 1'b0;
			strobe.port_rd <= 1'b0;
			strobe.port_wr <= 1'b0;
		end
		else
		begin
			iord_prev      <= iord_act;
			iowr_prev      <= iowr_act;
			strobe.port_rd <= iord_act & ~iord_prev;
			strobe.port_wr <= iowr_act & ~iowr_prev;
		end
	end

endmodule

`default_nettype wire

/* paging_regs.sv */
/* rom bit follows rstrom0 until two zclk edges after reset release
   zclk must run during reset for the rom bit to be loaded */
`timescale 1ns/1ps
`default_nettype none

module paging_regs import zport_pkg::*; (
	input  wire        zclk,
	input  wire        rst_n,
	input  z80_bus_t   bus,
	input  reg_wr_t    reg_wr,
	input  wire        rstrom0,
	output byte_t      p7ffd,
	output byte_t      peff7,
	output logic [5:0] pent1m_page,
	output logic       pent1m_rom,
	output logic       pent1m_1m_on,
	output logic       pent1m_ram0_0
);

	byte_t p7ffd_q;                 // raw 7ffd
	byte_t peff7_q;                 // raw eff7
	logic  rom_q;                   // visible rom bit
	logic  rst_sync1, rst_sync2;    // reset seen on zclk
	logic  block1m, block7ffd;

	assign block1m   = peff7_q[2];               // 1m paging off
	assign block7ffd = p7ffd_q[5] & block1m;     // 48k lock

	// high while in reset and two edges past it
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rst_sync1 <= 1'b1;
			rst_sync2 <= 1'b1;
		end
		else
		begin
			rst_sync1 <= 1'b0;
			rst_sync2 <= rst_sync1;
		end
	end

	//////////////////////////////
	// 7ffd
	//////////////////////////////
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			p7ffd_q <= '0;
		else if (reg_wr.p7ffd_wr && !block7ffd)
			p7ffd_q <= bus.wdata; // page bits 2..0 and screen bit 3
	end

	always_ff @(posedge zclk)
	begin
		if (rst_sync2)
			rom_q <= rstrom0;                     // boot rom choice
		else if (reg_wr.p7ffd_wr && !block7ffd)
			rom_q <= bus.wdata[4];
	end

	// eff7
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			peff7_q <= '0;
		else if (reg_wr.peff7_wr)
			peff7_q <= bus.wdata;
	end

	// masked views under the 1m block
	assign p7ffd = {(block1m ? 3'b000 : p7ffd_q[7:5]), rom_q, p7ffd_q[3:0]};
	assign peff7 = block1m ? {peff7_q[7], 1'b0, peff7_q[5:4], 3'b000, peff7_q[0]} : peff7_q;

	assign pent1m_page   = {p7ffd_q[7:5], p7ffd_q[2:0]};
	assign pent1m_rom    = p7ffd_q[4];
	assign pent1m_1m_on  = ~peff7_q[2];
	assign pent1m_ram0_0 = peff7_q[3];

endmodule

`default_nettype wire

/* port_decoder.sv */
/* purely combinational, shadow mode is the dos input alone
   write enables are only valid while the matching strobe is high */
`timescale 1ns/1ps
`default_nettype none

module port_decoder import zport_pkg::*; (
	input  z80_bus_t   bus,
	input  io_strobe_t strobe,
	input  wire        dos,
	output logic       porthit,
	output logic       external,
	output reg_wr_t    reg_wr,
	output rd_src_t    rd_src,
	output logic       ay_bc1,
	output logic       ay_bdir
);

	byte_t   loa;      // low address byte
	ay_sel_t ay_sel;
	logic    shadow;
	logic    vg_regs;  // one of the four wd93 register ports
	logic    pre_bc1, pre_bdir;

	assign loa     = bus.addr[7:0];
	assign ay_sel  = bus.addr[15:14];
	assign shadow  = dos;
	assign vg_regs = (loa == PORT_VGCOM) || (loa == PORT_VGTRK) ||
	                 (loa == PORT_VGSEC) || (loa == PORT_VGDAT);

	//////////////////////////////
	// hits and external flag
	//////////////////////////////
	assign porthit = (loa == PORT_FE) || (loa == PORT_F6) || (loa == PORT_FD) ||
	                 (loa == PORT_KMOUSE) || (loa == PORT_SDDAT) ||
	                 ((vg_regs || loa == PORT_VGSYS) && shadow) ||    // fdc only under dos
	                 ((loa == PORT_KJOY) && !shadow) ||
	                 ((loa == PORT_F7) && !shadow) ||
	                 ((loa == PORT_SDCFG) && !shadow);

	// ay data and fdc regs are driven by their own chips
	assign external = ((loa == PORT_FD) && (ay_sel == 2'b11)) || (vg_regs && shadow);

	//////////////////////////////
	// write enables
	//////////////////////////////
	assign reg_wr.p7ffd_wr  = strobe.port_wr && (loa == PORT_FD) && !bus.addr[15];
	assign reg_wr.peff7_wr  = strobe.port_wr && (loa == PORT_F7) && bus.addr[8] &&
	                          !bus.addr[12] && !shadow; // no eff7 under dos
	assign reg_wr.border_wr = strobe.port_wr && ((loa == PORT_FE) || (loa == PORT_F6));
	assign reg_wr.sdcfg_wr  = strobe.port_wr &&
	                          (((loa == PORT_SDCFG) && !shadow) ||
	                           ((loa == PORT_SDDAT) && shadow && bus.addr[15]));
	// in shadow 57 doubles as config when a15 is set
	assign reg_wr.sd_access = (loa == PORT_SDDAT) &&
	                          ((strobe.port_wr && (!shadow || !bus.addr[15])) || strobe.port_rd);

	// read source from the low byte only
	always_comb
	begin
		case (loa)
			PORT_FE, PORT_F6: rd_src = RD_KEYS;
			PORT_VGSYS:       rd_src = RD_VGSYS;
			PORT_KJOY:        rd_src = RD_KJOY;    // hidden by external in shadow
			PORT_KMOUSE:      rd_src = RD_MOUSE;
			PORT_SDCFG:       rd_src = RD_SDCFG;
			PORT_SDDAT:       rd_src = RD_SDDAT;
			default:          rd_src = RD_IDLE;    // f7 lands here too
		endcase
	end

	//////////////////////////////
	// ay chip control
	//////////////////////////////
	assign pre_bc1  = (loa == PORT_FD) && (ay_sel == 2'b11);      // fffd reg select
	assign pre_bdir = (loa == PORT_FD) && ay_sel[1];              // fffd and bffd

	assign ay_bc1  = pre_bc1 & ~bus.iorq_n & (~bus.rd_n | ~bus.wr_n);
	assign ay_bdir = pre_bdir & ~bus.iorq_n & ~bus.wr_n;

endmodule

`default_nettype wire

/* read_mux.sv */
/* dout is valid for any address, dataout says when to drive it
   external ports (ay data, fdc regs) never drive from here */
`timescale 1ns/1ps
`default_nettype none

module read_mux import zport_pkg::*; (
	input  z80_bus_t   bus,
	input  rd_src_t    rd_src,
	input  wire        external,
	input  wire        porthit,
	input  wire [4:0]  keys_in,
	input  wire        tape_read,
	input  wire [4:0]  kj_in,
	input  wire [7:0]  mus_in,
	input  wire        vg_intrq,
	input  wire        vg_drq,
	input  byte_t      sd_dataout,
	output byte_t      dout,
	output logic       dataout
);

	always_comb
	begin
		case (rd_src)
			RD_KEYS:  dout = {1'b1, tape_read, 1'b0, keys_in};
			RD_VGSYS: dout = {vg_intrq, vg_drq, 6'b111111}; // beta status
			RD_KJOY:  dout = {3'b000, kj_in};               // kempston
			RD_MOUSE: dout = mus_in;
			RD_SDCFG: dout = SDCFG_READ;
			RD_SDDAT: dout = sd_dataout;                    // last spi byte
			default:  dout = IDLE_BYTE;
		endcase
	end

	// drive the bus only on our own read cycle
	assign dataout = porthit & ~bus.iorq_n & ~bus.rd_n & ~external;

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
zport_pkg.sv
io_cycle_detect.sv
port_decoder.sv
paging_regs.sv
border_sd_regs.sv
read_mux.sv
zports_top.sv
tb_zports.sv

/* tb_checks.svh */
/* compare tasks and error counters for tb_zports
   included inside the testbench module, needs zport_pkg imported there */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int err_cnt    = 0;   // failed checks
int check_cnt  = 0;
int pass_tests = 0;
int fail_tests = 0;

//////////////////////////////
// typed compares
//////////////////////////////
task automatic check_byte(input string name, input byte_t got, input byte_t exp);
	check_cnt++;
	if (got !== exp)
	begin
		err_cnt++;
		$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	check_cnt++;
	if (got !== exp)
	begin
		err_cnt++;
		$display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
	end
endtask

task automatic check_page(input string name, input logic [5:0] got, input logic [5:0] exp);
	check_cnt++;
	if (got !== exp)
	begin
		err_cnt++;
		$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
	end
endtask

task automatic check_border(input string name, input logic [3:0] got, input logic [3:0] exp);
	check_cnt++;
	if (got !== exp)
	begin
		err_cnt++;
		$display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
	end
endtask

// pulse counts
task automatic check_count(input string name, input int got, input int exp);
	check_cnt++;
	if (got != exp)
	begin
		err_cnt++;
		$display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
	end
endtask

// one line per finished test
task automatic report_test(input string name, input int err_before);
	if (err_cnt == err_before)
	begin
		pass_tests++;
		$display("test %s: pass", name);
	end
	else
	begin
		fail_tests++;
		$display("test %s: fail, %0d errors", name, err_cnt - err_before);
	end
endtask

`endif

/* tb_zports.sv */
/* directed testbench for zports_top with inputs driven 2 ns after the rising zclk edge
   combinational outputs are sampled mid cycle, registers after the bus cycle ends */
`timescale 1ns/1ps
`default_nettype none

module tb_zports import zport_pkg::*; ();

	localparam int unsigned SEED    = 32'h8e363435;
	localparam int          N_BUS   = 39;             // bus cycles over all tests
	localparam int          BUS_CLK = 4;              // zclk edges per bus cycle
	localparam int          CYCLE_LIMIT = N_BUS * BUS_CLK + 8 + 100; // reset plus margin

	logic       zclk, rst_n;
	addr_t      a;
	byte_t      din;
	logic       iorq_n, rd_n, wr_n, dos, rstrom0;
	logic [4:0] keys_in, kj_in;
	logic       tape_read, vg_intrq, vg_drq;
	logic [7:0] mus_in;
	byte_t      sd_dataout;
	logic       porthit, dataout, ay_bc1, ay_bdir;
	byte_t      dout, p7ffd, peff7, sd_datain;
	logic [5:0] pent1m_page;
	logic       pent1m_rom, pent1m_1m_on, pent1m_ram0_0;
	logic [3:0] border;
	logic       beeper_wr, sdcs_n, sd_start;

	// values seen mid cycle during the last bus cycle
	byte_t cap_dout, cap_sd_datain;
	logic  cap_hit, cap_drv, cap_bc1, cap_bdir;
	int    beep_cnt = 0;
	int    start_cnt = 0;
	int    cycle_cnt = 0;
	int unsigned seed_v = SEED;

	`include "tb_checks.svh"

	zports_top zports_top_inst (.zclk(zclk), .rst_n(rst_n), .a(a), .din(din), .iorq_n(iorq_n),
		.rd_n(rd_n), .wr_n(wr_n), .dos(dos), .rstrom0(rstrom0), .keys_in(keys_in),
		.tape_read(tape_read), .kj_in(kj_in), .mus_in(mus_in), .vg_intrq(vg_intrq),
		.vg_drq(vg_drq), .sd_dataout(sd_dataout), .porthit(porthit), .dout(dout),
		.dataout(dataout), .ay_bc1(ay_bc1), .ay_bdir(ay_bdir), .p7ffd(p7ffd), .peff7(peff7),
		.pent1m_page(pent1m_page), .pent1m_rom(pent1m_rom), .pent1m_1m_on(pent1m_1m_on),
		.pent1m_ram0_0(pent1m_ram0_0), .border(border), .beeper_wr(beeper_wr),
		.sdcs_n(sdcs_n), .sd_start(sd_start), .sd_datain(sd_datain));

	initial
	begin
		zclk = 1'b0;
		forever #10 zclk = ~zclk;   // 50 MHz
	end

	// one count per negedge for each one cycle pulse
	always @(negedge zclk)
	begin
		if (beeper_wr)
			beep_cnt++;
		if (sd_start)
			start_cnt++;
	end

	// watchdog
	always @(posedge zclk)
	begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT)
		begin
			$display("timeout: the test sequence did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Something failed");
			$finish;
		end
	end

	//////////////////////////////
	// bus tasks
	//////////////////////////////
	// three active edges and one idle edge
	// entered and left 2 ns after posedge
	task automatic bus_cycle(input addr_t addr, input byte_t data, input logic is_wr);
		a      = addr;
		din    = data;
		iorq_n = 1'b0;
		rd_n   = is_wr;
		wr_n   = ~is_wr;
		@(negedge zclk);
		cap_dout      = dout;
		cap_hit       = porthit;
		cap_drv       = dataout;
		cap_bc1       = ay_bc1;
		cap_bdir      = ay_bdir;
		cap_sd_datain = sd_datain;
		repeat (3) @(posedge zclk);
		#2;
		iorq_n = 1'b1;          // end the cycle
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		@(posedge zclk);
		#2;
	endtask

	task automatic io_write(input addr_t addr, input byte_t data);
		bus_cycle(addr, data, 1'b1);
	endtask

	task automatic io_read(input addr_t addr);
		bus_cycle(addr, 8'h00, 1'b0);
	endtask

	// read one port and check data, hit and drive enable
	task automatic read_port(input addr_t addr, input byte_t exp_d, input logic exp_hit,
	                         input logic exp_drv, input logic chk_d);
		io_read(addr);
		if (chk_d)
			check_byte($sformatf("dout@%h dos=%0b", addr, dos), cap_dout, exp_d);
		check_bit($sformatf("porthit@%h dos=%0b", addr, dos), cap_hit, exp_hit);
		check_bit($sformatf("dataout@%h dos=%0b", addr, dos), cap_drv, exp_drv);
	endtask

	//////////////////////////////
	// directed tests
	//////////////////////////////
	task automatic test_reset();
		int e0;
		e0 = err_cnt;
		check_byte("p7ffd", p7ffd, {3'b000, rstrom0, 4'h0});   // rom bit from rstrom0
		check_byte("peff7", peff7, 8'h00);
		check_border("border", border, 4'h0);
		check_bit("sdcs_n", sdcs_n, 1'b1);
		check_page("pent1m_page", pent1m_page, 6'h00);
		check_bit("pent1m_rom", pent1m_rom, 1'b0);             // raw 7ffd bit
		check_bit("pent1m_1m_on", pent1m_1m_on, 1'b1);
		check_bit("pent1m_ram0_0", pent1m_ram0_0, 1'b0);
		report_test("reset defaults", e0);
	endtask

	task automatic test_reads();
		int    e0;
		byte_t keys_b, joy_b, sys_b;
		e0     = err_cnt;
		keys_b = {1'b1, tape_read, 1'b0, keys_in};
		joy_b  = {3'b000, kj_in};
		sys_b  = {vg_intrq, vg_drq, 6'b111111};
		dos = 1'b0;
		read_port(16'h00FE, keys_b, 1'b1, 1'b1, 1'b1);
		read_port(16'h00F6, keys_b, 1'b1, 1'b1, 1'b1);
		read_port(16'h001F, joy_b, 1'b1, 1'b1, 1'b1);       // kempston outside dos
		read_port(16'hFADF, mus_in, 1'b1, 1'b1, 1'b1);
		read_port(16'h0077, SDCFG_READ, 1'b1, 1'b1, 1'b1);
		read_port(16'h0057, sd_dataout, 1'b1, 1'b1, 1'b1);
		read_port(16'hEFF7, IDLE_BYTE, 1'b1, 1'b1, 1'b1);   // eff7 is write only
		read_port(16'hFFFD, IDLE_BYTE, 1'b1, 1'b0, 1'b0);   // ay drives its own data
		read_port(16'h00FF, IDLE_BYTE, 1'b0, 1'b0, 1'b0);
		read_port(16'h003F, IDLE_BYTE, 1'b0, 1'b0, 1'b0);
		dos = 1'b1;
		read_port(16'h00FE, keys_b, 1'b1, 1'b1, 1'b1);
		read_port(16'h001F, IDLE_BYTE, 1'b1, 1'b0, 1'b0);   // now a wd93 register
		read_port(16'h003F, IDLE_BYTE, 1'b1, 1'b0, 1'b0);
		read_port(16'h005F, IDLE_BYTE, 1'b1, 1'b0, 1'b0);
		read_port(16'h007F, IDLE_BYTE, 1'b1, 1'b0, 1'b0);
		read_port(16'h00FF, sys_b, 1'b1, 1'b1, 1'b1);
		read_port(16'hEFF7, IDLE_BYTE, 1'b0, 1'b0, 1'b0);
		read_port(16'h0077, IDLE_BYTE, 1'b0, 1'b0, 1'b0);
		read_port(16'h0057, sd_dataout, 1'b1, 1'b1, 1'b1);
		dos = 1'b0;
		report_test("port reads", e0);
	endtask

	task automatic test_paging();
		int    e0;
		byte_t d, d2, d3, e;
		e0 = err_cnt;
		d  = byte_t'($urandom) & 8'hDF;      // no lock bit yet
		d2 = byte_t'($urandom) | 8'h20;
		d3 = ~d2;                            // differs from d2 in every bit
		e  = byte_t'($urandom) | 8'h0C;      // block 1m and ram0
		io_write(16'h7FFD, d);
		check_byte("p7ffd", p7ffd, d);
		check_page("pent1m_page", pent1m_page, {d[7:5], d[2:0]});
		check_bit("pent1m_rom", pent1m_rom, d[4]);
		io_write(16'hEFF7, e);
		check_byte("peff7", peff7, e & 8'hB1);
		check_byte("p7ffd", p7ffd, {3'b000, d[4:0]});
		check_bit("pent1m_1m_on", pent1m_1m_on, 1'b0);
		check_bit("pent1m_ram0_0", pent1m_ram0_0, 1'b1);
		io_write(16'h7FFD, d2);              // sets the lock while still open
		check_byte("p7ffd", p7ffd, {3'b000, d2[4:0]});
		io_write(16'h7FFD, d3);              // locked
		check_byte("p7ffd", p7ffd, {3'b000, d2[4:0]});
		check_page("pent1m_page", pent1m_page, {d2[7:5], d2[2:0]});
		io_write(16'hEFF7, 8'h00);
		check_byte("peff7", peff7, 8'h00);
		check_bit("pent1m_1m_on", pent1m_1m_on, 1'b1);
		dos = 1'b1;
		io_write(16'hEFF7, 8'hFF);           // no eff7 under dos
		check_byte("peff7", peff7, 8'h00);
		dos = 1'b0;
		io_write(16'h7FFD, d3);              // unlocked again
		check_byte("p7ffd", p7ffd, d3);
		report_test("paging", e0);
	endtask

	task automatic test_border();
		int    e0, b0;
		byte_t d;
		e0 = err_cnt;
		d  = byte_t'($urandom);
		b0 = beep_cnt;
		io_write(16'h00FE, d);               // a3 set
		check_border("border", border, {1'b0, d[2:0]});
		check_count("beeper_wr pulses", beep_cnt - b0, 1);
		d  = byte_t'($urandom);
		b0 = beep_cnt;
		io_write(16'h12F6, d);               // a3 clear
		check_border("border", border, {1'b1, d[2:0]});
		check_count("beeper_wr pulses", beep_cnt - b0, 0);
		report_test("border", e0);
	endtask

	task automatic test_sd();
		int    e0, s0;
		byte_t d;
		e0 = err_cnt;
		s0 = start_cnt;
		d  = byte_t'($urandom);
		dos = 1'b0;
		io_write(16'h0077, 8'h00);
		check_bit("sdcs_n", sdcs_n, 1'b0);
		io_write(16'h0077, 8'h02);
		check_bit("sdcs_n", sdcs_n, 1'b1);
		dos = 1'b1;
		io_write(16'h8057, 8'h00);           // config in shadow
		check_bit("sdcs_n", sdcs_n, 1'b0);
		check_count("sd_start pulses", start_cnt - s0, 0);
		io_write(16'h0057, d);
		check_byte("sd_datain", cap_sd_datain, d);
		io_read(16'h0057);
		check_byte("sd_datain", cap_sd_datain, 8'hFF);
		check_byte("dout@0057", cap_dout, sd_dataout);
		dos = 1'b0;
		io_write(16'h8057, 8'h02);           // data access rather than config
		check_bit("sdcs_n", sdcs_n, 1'b0);
		check_count("sd_start pulses", start_cnt - s0, 3);
		report_test("sd card", e0);
	endtask

	task automatic test_ay();
		int e0;
		e0 = err_cnt;
		io_write(16'hFFFD, 8'h07);
		check_bit("ay_bc1 wr fffd", cap_bc1, 1'b1);
		check_bit("ay_bdir wr fffd", cap_bdir, 1'b1);
		io_read(16'hFFFD);
		check_bit("ay_bc1 rd fffd", cap_bc1, 1'b1);
		check_bit("ay_bdir rd fffd", cap_bdir, 1'b0);
		io_write(16'hBFFD, 8'h3F);
		check_bit("ay_bc1 wr bffd", cap_bc1, 1'b0);
		check_bit("ay_bdir wr bffd", cap_bdir, 1'b1);
		io_read(16'hBFFD);
		check_bit("ay_bc1 rd bffd", cap_bc1, 1'b0);
		check_bit("ay_bdir rd bffd", cap_bdir, 1'b0);
		io_write(16'h7FFD, 8'h00);
		check_bit("ay_bc1 wr 7ffd", cap_bc1, 1'b0);
		check_bit("ay_bdir wr 7ffd", cap_bdir, 1'b0);
		report_test("ay lines", e0);
	endtask

	initial
	begin
		void'($urandom(seed_v));
		rst_n      = 1'b0;
		a          = '0;
		din        = '0;
		iorq_n     = 1'b1;
		rd_n       = 1'b1;
		wr_n       = 1'b1;
		dos        = 1'b0;
		rstrom0    = 1'b1;
		keys_in    = 5'($urandom);
		tape_read  = 1'($urandom);
		kj_in      = 5'($urandom);
		mus_in     = 8'($urandom);
		vg_intrq   = 1'($urandom);
		vg_drq     = 1'($urandom);
		sd_dataout = byte_t'($urandom);
		repeat (4) @(posedge zclk);
		#2 rst_n = 1'b1;
		repeat (3) @(posedge zclk);           // let the rom bit settle
		#2;
		test_reset();
		test_reads();
		test_paging();
		test_border();
		test_sd();
		test_ay();
		$display("tests passed %0d, tests failed %0d, checks %0d, errors %0d",
			pass_tests, fail_tests, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

/* zport_pkg.sv */
/* shared types and port map of the zclk-only port block
   only the low address byte is compared, except where a15/a12/a8 are noted */
`default_nettype none

package zport_pkg;

	//////////////////////////////
	// widths
	//////////////////////////////
	localparam int ADDR_W   = 16;
	localparam int DATA_W   = 8;
	localparam int AY_SEL_W = 2;
	localparam int RD_SRC_W = 3;

	typedef logic [ADDR_W-1:0]   addr_t;   // z80 address
	typedef logic [DATA_W-1:0]   byte_t;   // data byte
	typedef logic [AY_SEL_W-1:0] ay_sel_t; // a15:a14 for the FD ports
	typedef logic [RD_SRC_W-1:0] rd_src_t; // read data source code

	// raw z80 bus, 27 bits
	typedef struct packed {
		addr_t addr;
		byte_t wdata;
		logic  iorq_n;
		logic  rd_n;
		logic  wr_n;
	} z80_bus_t;

	// single zclk pulses, one per bus cycle
	typedef struct packed {
		logic port_wr;
		logic port_rd;
	} io_strobe_t;

	// write enables, strobe already folded in
	typedef struct packed {
		logic p7ffd_wr;
		logic peff7_wr;
		logic border_wr;
		logic sdcfg_wr;
		logic sd_access; // sd data read or write
	} reg_wr_t;

	//////////////////////////////
	// low address bytes
	//////////////////////////////
	localparam byte_t PORT_FE     = 8'hFE;
	localparam byte_t PORT_F6     = 8'hF6; // border mirror
	localparam byte_t PORT_FD     = 8'hFD; // 7ffd and ay
	localparam byte_t PORT_F7     = 8'hF7; // eff7
	localparam byte_t PORT_VGCOM  = 8'h1F; // wd93 regs in shadow
	localparam byte_t PORT_VGTRK  = 8'h3F;
	localparam byte_t PORT_VGSEC  = 8'h5F;
	localparam byte_t PORT_VGDAT  = 8'h7F;
	localparam byte_t PORT_VGSYS  = 8'hFF;
	localparam byte_t PORT_KJOY   = 8'h1F; // same byte as vgcom, outside shadow
	localparam byte_t PORT_KMOUSE = 8'hDF;
	localparam byte_t PORT_SDCFG  = 8'h77;
	localparam byte_t PORT_SDDAT  = 8'h57;

	localparam byte_t IDLE_BYTE  = 8'hFF; // floating bus
	localparam byte_t SDCFG_READ = 8'h00; // card present, not write protected

	// read source codes
	localparam rd_src_t RD_KEYS  = 3'd0;
	localparam rd_src_t RD_VGSYS = 3'd1;
	localparam rd_src_t RD_KJOY  = 3'd2;
	localparam rd_src_t RD_MOUSE = 3'd3;
	localparam rd_src_t RD_SDCFG = 3'd4;
	localparam rd_src_t RD_SDDAT = 3'd5;
	localparam rd_src_t RD_IDLE  = 3'd7;

endpackage

`default_nettype wire

/* zports_top.sv */
/* single zclk domain, z80 bus inputs sampled directly on zclk
   no wait states, every port answers in the cycle it is addressed */
`timescale 1ns/1ps
`default_nettype none

module zports_top import zport_pkg::*; (
	input  wire        zclk,
	input  wire        rst_n,
	input  addr_t      a,
	input  byte_t      din,
	input  wire        iorq_n,
	input  wire        rd_n,
	input  wire        wr_n,
	input  wire        dos,
	input  wire        rstrom0,
	input  wire [4:0]  keys_in,
	input  wire        tape_read,
	input  wire [4:0]  kj_in,
	input  wire [7:0]  mus_in,
	input  wire        vg_intrq,
	input  wire        vg_drq,
	input  byte_t      sd_dataout,
	output logic       porthit,
	output byte_t      dout,
	output logic       dataout,
	output logic       ay_bc1,
	output logic       ay_bdir,
	output byte_t      p7ffd,
	output byte_t      peff7,
	output logic [5:0] pent1m_page,
	output logic       pent1m_rom,
	output logic       pent1m_1m_on,
	output logic       pent1m_ram0_0,
	output logic [3:0] border,
	output logic       beeper_wr,
	output logic       sdcs_n,
	output logic       sd_start,
	output byte_t      sd_datain
);

	z80_bus_t   bus;
	io_strobe_t strobe;
	reg_wr_t    reg_wr;
	rd_src_t    rd_src;
	logic       external;

	assign bus = '{addr: a, wdata: din, iorq_n: iorq_n, rd_n: rd_n, wr_n: wr_n};

	io_cycle_detect io_cycle_detect_inst (.zclk(zclk), .rst_n(rst_n), .bus(bus), .strobe(strobe));

	port_decoder port_decoder_inst (.bus(bus), .strobe(strobe), .dos(dos), .porthit(porthit),
		.external(external), .reg_wr(reg_wr), .rd_src(rd_src), .ay_bc1(ay_bc1), .ay_bdir(ay_bdir));

	paging_regs paging_regs_inst (.zclk(zclk), .rst_n(rst_n), .bus(bus), .reg_wr(reg_wr),
		.rstrom0(rstrom0), .p7ffd(p7ffd), .peff7(peff7), .pent1m_page(pent1m_page),
		.pent1m_rom(pent1m_rom), .pent1m_1m_on(pent1m_1m_on), .pent1m_ram0_0(pent1m_ram0_0));

	border_sd_regs border_sd_regs_inst (.zclk(zclk), .rst_n(rst_n), .bus(bus), .strobe(strobe),
		.reg_wr(reg_wr), .border(border), .beeper_wr(beeper_wr), .sdcs_n(sdcs_n),
		.sd_start(sd_start), .sd_datain(sd_datain));

	read_mux read_mux_inst (.bus(bus), .rd_src(rd_src), .external(external), .porthit(porthit),
		.keys_in(keys_in), .tape_read(tape_read), .kj_in(kj_in), .mus_in(mus_in),
		.vg_intrq(vg_intrq), .vg_drq(vg_drq), .sd_dataout(sd_dataout),
		.dout(dout), .dataout(dataout));

endmodule

`default_nettype wire
